// File: hdl/game_pkg.sv
package game_pkg;
	import screen_pkg::*;

	// Display mode, stepped by the display button
	typedef enum logic [1:0] {
		MODE_BLANK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME = 2'd2
	} game_mode_t;

	// Player ship, only its left edge moves
	typedef struct packed {
		coord_t left_x;
	} ship_t;

	// Marching alien row
	typedef struct packed {
		coord_t left_x;
		coord_t top_y;
		logic dir_right;
	} formation_t;

	// Per-pixel hit flags, mode rides along with the pixel
	typedef struct packed {
		game_mode_t mode;
		logic in_screen;
		logic barrier_line;
		logic lives_line;
		logic ship;
		logic alien;
	} pixel_hits_t;

	//////////////////////////////
	// Sprite sizes
	//////////////////////////////

	// Ship box and movement
	localparam coord_t SHIP_Y = 11'd410;
	localparam coord_t SHIP_W = 11'd40;
	localparam coord_t SHIP_H = 11'd20;
	localparam coord_t SHIP_START_X = 11'd300;
	localparam coord_t SHIP_STEP = 11'd4;

	// Alien box and spacing along the row
	localparam coord_t ALIEN_W = 11'd30;
	localparam coord_t ALIEN_H = 11'd20;
	localparam coord_t ALIEN_PITCH = 11'd50;

	// Formation home position and drop per reversal
	localparam coord_t FORM_START_X = 11'd195;
	localparam coord_t FORM_START_Y = 11'd180;
	localparam coord_t DROP_Y = 11'd10;

endpackage

// File: hdl/game_state.sv
`timescale 1ns/1ps

module game_state
	import screen_pkg::*, game_pkg::*;
#(
	parameter int ALIEN_COLS = 6,
	parameter int STEP_FRAMES = 2,
	parameter int STEP_X = 10
) (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic button_left,
	input logic button_right,
	input logic button_display,
	output game_mode_t mode,
	output ship_t ship,
	output formation_t formation
);

	// Left edge of first alien to right edge of last one
	localparam coord_t SPAN = coord_t'((ALIEN_COLS - 1) * ALIEN_PITCH + ALIEN_W);
	localparam coord_t MARCH_STEP = coord_t'(STEP_X);
	localparam coord_t SHIP_MAX_X = SCREEN_W - SHIP_W;

	// Frame counter sized for the step period
	localparam int CNT_W = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(STEP_FRAMES - 1);

	// Home positions, also restored on each display pulse
	localparam ship_t SHIP_HOME = '{left_x: SHIP_START_X};
	localparam formation_t FORM_HOME = '{
		left_x: FORM_START_X,
		top_y: FORM_START_Y,
		dir_right: 1'b1
	};

	logic [CNT_W-1:0] frame_cnt;
	logic game_frame;
	logic at_edge;
	game_mode_t mode_next;
	ship_t ship_next;
	formation_t form_next;

	// Only frames seen in game mode move anything
	assign game_frame = frame_start && (mode == MODE_GAME);

	// Blank -> start -> game -> blank
	always_comb begin
		unique case (mode)
			MODE_BLANK: mode_next = MODE_START;
			MODE_START: mode_next = MODE_GAME;
			default: mode_next = MODE_BLANK;
		endcase
	end

	//////////////////////////////
	// Ship movement
	//////////////////////////////
	always_comb begin
		ship_next = ship;
		// Both buttons cancel out
		if (button_right && !button_left) begin
			if (ship.left_x + SHIP_STEP <= SHIP_MAX_X)
				ship_next.left_x = ship.left_x + SHIP_STEP;
			else
				ship_next.left_x = SHIP_MAX_X;
		end else if (button_left && !button_right) begin
			if (ship.left_x >= SHIP_STEP)
				ship_next.left_x = ship.left_x - SHIP_STEP;
			else
				ship_next.left_x = '0;
		end
	end

	//////////////////////////////
	// Formation march
	//////////////////////////////
	always_comb begin
		form_next = formation;
		// Would the next sideways step leave the screen
		if (formation.dir_right)
			at_edge = (formation.left_x + SPAN + MARCH_STEP) > SCREEN_W;
		else
			at_edge = formation.left_x < MARCH_STEP;
		// At an edge: drop and turn around instead of moving
		if (at_edge) begin
			form_next.top_y = formation.top_y + DROP_Y;
			form_next.dir_right = !formation.dir_right;
		end else if (formation.dir_right) begin
			form_next.left_x = formation.left_x + MARCH_STEP;
		end else begin
			form_next.left_x = formation.left_x - MARCH_STEP;
		end
	end

	// Display pulse wins over a frame in the same cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode <= MODE_BLANK;
			ship <= SHIP_HOME;
			formation <= FORM_HOME;
			frame_cnt <= '0;
		end else if (button_display) begin
			mode <= mode_next;
			ship <= SHIP_HOME;
			formation <= FORM_HOME;
			frame_cnt <= '0;
		end else if (game_frame) begin
			ship <= ship_next;
			if (frame_cnt == LAST_CNT) begin
				frame_cnt <= '0;
				formation <= form_next;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// Encoding 2'b11 is never reached
	a_mode_valid: assert property (@(posedge clk) disable iff (rst)
		mode inside {MODE_BLANK, MODE_START, MODE_GAME});

	// Row stays inside the visible width across every step
	a_row_on_screen: assert property (@(posedge clk) disable iff (rst)
		(formation.left_x + SPAN) <= SCREEN_W);

endmodule

// File: hdl/invaders_display.sv
`timescale 1ns/1ps

module invaders_display
	import screen_pkg::*, game_pkg::*;
#(
	parameter int ALIEN_COLS = 6,
	parameter int STEP_FRAMES = 2,
	parameter int STEP_X = 10
) (
	input logic clk,
	input logic rst,
	input logic frame_start,
	input logic button_left,
	input logic button_right,
	input logic button_display,
	input coord_t x,
	input coord_t y,
	output rgb_t rgb
);

	// Game state towards the decode stage
	game_mode_t mode;
	ship_t ship;
	formation_t formation;

	// Decoded pixel towards the colour stage
	pixel_hits_t hits;

	//////////////////////////////
	// Execute: mode, ship, march
	//////////////////////////////
	game_state #(
		.ALIEN_COLS(ALIEN_COLS),
		.STEP_FRAMES(STEP_FRAMES),
		.STEP_X(STEP_X)
	) i_game_state (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.button_left(button_left),
		.button_right(button_right),
		.button_display(button_display),
		.mode(mode),
		.ship(ship),
		.formation(formation)
	);

	// Decode: pixel against each object, 1 cycle
	object_decode #(
		.ALIEN_COLS(ALIEN_COLS)
	) i_object_decode (
		.clk(clk),
		.rst(rst),
		.x(x),
		.y(y),
		.mode(mode),
		.ship(ship),
		.formation(formation),
		.hits(hits)
	);

	// Result: priority colour, 1 more cycle
	pixel_result i_pixel_result (
		.clk(clk),
		.rst(rst),
		.hits(hits),
		.rgb(rgb)
	);

endmodule

// File: hdl/object_decode.sv
`timescale 1ns/1ps

module object_decode
	import screen_pkg::*, game_pkg::*;
#(
	parameter int ALIEN_COLS = 6
) (
	input logic clk,
	input logic rst,
	input coord_t x,
	input coord_t y,
	input game_mode_t mode,
	input ship_t ship,
	input formation_t formation,
	output pixel_hits_t hits
);

	pixel_hits_t hits_d;
	logic alien_row;
	logic alien_any;

	// Row band shared by every alien
	assign alien_row = (y >= formation.top_y) && (y < formation.top_y + ALIEN_H);

	//////////////////////////////
	// Alien boxes along the row
	//////////////////////////////
	always_comb begin
		coord_t box_x;
		alien_any = 1'b0;
		for (int i = 0; i < ALIEN_COLS; i++) begin
			// Left edge of alien i
			box_x = formation.left_x + coord_t'(i * ALIEN_PITCH);
			if ((x >= box_x) && (x < box_x + ALIEN_W))
				alien_any = 1'b1;
		end
	end

	// Hit tests for the current pixel
	always_comb begin
		hits_d.mode = mode;
		hits_d.in_screen = (x < SCREEN_W) && (y < SCREEN_H);
		hits_d.barrier_line = (y == BARRIER_LINE_Y);
		hits_d.lives_line = (y == LIVES_TOP_Y) || (y == LIVES_BOTTOM_Y);
		// Ship box, fixed row, moving left edge
		hits_d.ship = (x >= ship.left_x) && (x < ship.left_x + SHIP_W)
			&& (y >= SHIP_Y) && (y < SHIP_Y + SHIP_H);
		hits_d.alien = alien_row && alien_any;
	end

	// One pixel per cycle, no stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			hits <= '0;
		else
			hits <= hits_d;
	end

endmodule

// File: hdl/pixel_result.sv
`timescale 1ns/1ps

module pixel_result
	import screen_pkg::*, game_pkg::*;
(
	input logic clk,
	input logic rst,
	input pixel_hits_t hits,
	output rgb_t rgb
);

	rgb_t rgb_d;

	//////////////////////////////
	// Colour priority
	//////////////////////////////
	always_comb begin
		rgb_d = COLOR_SPACE;
		// Blanking area always black
		if (hits.in_screen) begin
			unique case (hits.mode)
				MODE_START: rgb_d = COLOR_START;
				MODE_GAME: begin
					// First match wins, top to bottom
					if (hits.barrier_line)
						rgb_d = COLOR_BLUE;
					else if (hits.ship)
						rgb_d = COLOR_SHIP;
					else if (hits.lives_line)
						rgb_d = COLOR_GREEN;
					else if (hits.alien)
						rgb_d = COLOR_ALIEN;
					else
						rgb_d = COLOR_SPACE;
				end
				// Blank screen
				default: rgb_d = COLOR_SPACE;
			endcase
		end
	end

	// Output pixel register
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rgb <= COLOR_SPACE;
		else
			rgb <= rgb_d;
	end

	// Off-screen pixel comes out black on the next cycle
	a_offscreen_black: assert property (@(posedge clk) disable iff (rst)
		!hits.in_screen |=> (rgb == COLOR_SPACE));

endmodule

// File: hdl/screen_pkg.sv
package screen_pkg;

	//////////////////////////////
	// Pixel coordinate and colour types
	//////////////////////////////

	// Wide enough for the full VGA line including blanking
	typedef logic [10:0] coord_t;

	// Colour byte, blue in the top bits, red at the bottom
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	//////////////////////////////
	// Screen geometry
	//////////////////////////////

	// Visible area
	localparam coord_t SCREEN_W = 11'd640;
	localparam coord_t SCREEN_H = 11'd480;

	// Blue line under the barrier zone
	localparam coord_t BARRIER_LINE_Y = 11'd400;

	// Green border lines of the extra-lives strip
	localparam coord_t LIVES_TOP_Y = 11'd445;
	localparam coord_t LIVES_BOTTOM_Y = 11'd479;

	//////////////////////////////
	// Palette
	//////////////////////////////

	localparam rgb_t COLOR_SPACE = 8'b00000000;
	localparam rgb_t COLOR_START = 8'b11111111;
	localparam rgb_t COLOR_BLUE = 8'b11000000;
	localparam rgb_t COLOR_GREEN = 8'b00111000;
	localparam rgb_t COLOR_SHIP = 8'b01111000;
	localparam rgb_t COLOR_ALIEN = 8'b10101010;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f \
	--top-module tb_invaders_display -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0

// File: src.f
+incdir+tests
hdl/screen_pkg.sv
hdl/game_pkg.sv
hdl/game_state.sv
hdl/object_decode.sv
hdl/pixel_result.sv
hdl/invaders_display.sv
tests/tb_invaders_display.sv

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// March reference
//////////////////////////////

// Formation position after a count of game frames
// One march step per STEP_FRAMES frames, from the home position
function automatic formation_t march_left_x(input int frames);
	formation_t f;
	int lx;
	int ty;
	int right_edge;
	int steps;
	logic dir;
	lx = int'(FORM_START_X);
	ty = int'(FORM_START_Y);
	dir = 1'b1;
	steps = frames / STEP_FRAMES;
	for (int s = 0; s < steps; s++) begin
		// Right edge of the last alien in the row
		right_edge = lx + (ALIEN_COLS - 1) * int'(ALIEN_PITCH) + int'(ALIEN_W);
		// Would the step leave the screen: drop and turn instead
		if (dir ? (right_edge + STEP_X > int'(SCREEN_W)) : (lx - STEP_X < 0)) begin
			ty = ty + int'(DROP_Y);
			dir = !dir;
		end else if (dir) begin
			lx = lx + STEP_X;
		end else begin
			lx = lx - STEP_X;
		end
	end
	f.left_x = coord_t'(lx);
	f.top_y = coord_t'(ty);
	f.dir_right = dir;
	return f;
endfunction

//////////////////////////////
// Compare task
//////////////////////////////

// Output colour against expected
task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
	if (got !== exp) begin
		$display("ERROR: time %0t %s got %b expected %b", $time, name, got, exp);
		fail_run("wrong pixel colour");
	end else begin
		checks_done++;
	end
endtask

`endif

// File: tests/tb_invaders_display.sv
`timescale 1ns/1ps

module tb_invaders_display
	import screen_pkg::*, game_pkg::*;
;

	localparam int ALIEN_COLS = 6;
	localparam int STEP_FRAMES = 2;
	localparam int STEP_X = 10;

	// Cycle cost of each kind of stimulus
	localparam int PULSE_CYCLES = 2;
	localparam int FRAME_CYCLES = 4;
	localparam int PROBE_CYCLES = 3;

	// One table row of pulses, frames with buttons, probe and colour
	// With rel set the probe is an offset from the first alien
	typedef struct packed {
		int pulses;
		int frames;
		logic left;
		logic right;
		logic rel;
		int px;
		int py;
		rgb_t exp;
	} entry_t;

	logic clk;
	logic rst;
	logic frame_start;
	logic button_left;
	logic button_right;
	logic button_display;
	coord_t x;
	coord_t y;
	rgb_t rgb;

	entry_t entries[$];
	game_mode_t tb_mode;
	int game_frames;
	int checks_done;
	int cycle_count = 0;
	int timeout_limit;

	invaders_display #(
		.ALIEN_COLS(ALIEN_COLS),
		.STEP_FRAMES(STEP_FRAMES),
		.STEP_X(STEP_X)
	) i_invaders_display (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.button_left(button_left),
		.button_right(button_right),
		.button_display(button_display),
		.x(x),
		.y(y),
		.rgb(rgb)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_checks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
			fail_run("timeout: the table did not finish within the cycle limit");
	end

	task automatic add_entry(input int pulses, input int frames, input logic left,
		input logic right, input logic rel, input int px, input int py, input rgb_t exp);
		entry_t e;
		e = '{pulses, frames, left, right, rel, px, py, exp};
		entries.push_back(e);
	endtask

	// Blank, start, game, then back to blank
	function automatic game_mode_t next_mode(input game_mode_t m);
		case (m)
			MODE_BLANK: return MODE_START;
			MODE_START: return MODE_GAME;
			default: return MODE_BLANK;
		endcase
	endfunction

	task automatic send_display_pulse();
		@(posedge clk);
		button_display <= 1'b1;
		@(posedge clk);
		button_display <= 1'b0;
		// Pulse also sends ship and row home
		tb_mode = next_mode(tb_mode);
		game_frames = 0;
	endtask

	// Single frame_start pulse with the next one 4 cycles later
	task automatic send_frame(input logic left, input logic right);
		@(posedge clk);
		frame_start <= 1'b1;
		button_left <= left;
		button_right <= right;
		@(posedge clk);
		frame_start <= 1'b0;
		repeat (2) @(posedge clk);
		if (tb_mode == MODE_GAME)
			game_frames++;
	endtask

	task automatic apply_entry(input entry_t e);
		formation_t f;
		int px;
		int py;
		repeat (e.pulses) send_display_pulse();
		repeat (e.frames) send_frame(e.left, e.right);
		px = e.px;
		py = e.py;
		if (e.rel) begin
			f = march_left_x(game_frames);
			px = int'(f.left_x) + e.px;
			py = int'(f.top_y) + e.py;
		end
		@(posedge clk);
		x <= coord_t'(px);
		y <= coord_t'(py);
		button_left <= 1'b0;
		button_right <= 1'b0;
		// Two stage pipeline sampled mid cycle
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_rgb($sformatf("rgb at (%0d,%0d)", px, py), rgb, e.exp);
	endtask

	initial begin
		rst <= 1'b1;
		frame_start <= 1'b0;
		button_left <= 1'b0;
		button_right <= 1'b0;
		button_display <= 1'b0;
		x <= '0;
		y <= '0;
		tb_mode = MODE_BLANK;
		game_frames = 0;
		checks_done = 0;

		//////////////////////////////
		// Stimulus table
		//////////////////////////////
		// After reset
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 0, 0, COLOR_SPACE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 320, 240, COLOR_SPACE);
		// Mode cycle
		add_entry(1, 0, 1'b0, 1'b0, 1'b0, 100, 100, COLOR_START);
		add_entry(1, 0, 1'b0, 1'b0, 1'b0, 10, 400, COLOR_BLUE);
		add_entry(1, 0, 1'b0, 1'b0, 1'b0, 100, 100, COLOR_SPACE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 10, 400, COLOR_SPACE);
		// Game screen at home positions
		add_entry(2, 0, 1'b0, 1'b0, 1'b0, 10, 400, COLOR_BLUE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 10, 445, COLOR_GREEN);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 10, 479, COLOR_GREEN);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 320, 415, COLOR_SHIP);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 200, 185, COLOR_ALIEN);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 100, 300, COLOR_SPACE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 700, 100, COLOR_SPACE);
		// Ship right 5 frames to x 320 and both buttons hold it
		add_entry(0, 5, 1'b0, 1'b1, 1'b0, 355, 415, COLOR_SHIP);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 305, 415, COLOR_SPACE);
		add_entry(0, 3, 1'b1, 1'b1, 1'b0, 355, 415, COLOR_SHIP);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 319, 415, COLOR_SPACE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 320, 415, COLOR_SHIP);
		// March after 8 frames and after 40 past the right wall reversal
		add_entry(0, 0, 1'b0, 1'b0, 1'b1, 2, 2, COLOR_ALIEN);
		add_entry(0, 32, 1'b0, 1'b0, 1'b1, 2, 2, COLOR_ALIEN);
		add_entry(0, 0, 1'b0, 1'b0, 1'b1, -1, 2, COLOR_SPACE);
		add_entry(0, 0, 1'b0, 1'b0, 1'b1, 2, -3, COLOR_SPACE);
		// Back into game mode with home positions again
		add_entry(3, 0, 1'b0, 1'b0, 1'b0, 200, 185, COLOR_ALIEN);
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 320, 415, COLOR_SHIP);
		// Left part of the home ship box, outside the box at x 320
		add_entry(0, 0, 1'b0, 1'b0, 1'b0, 305, 415, COLOR_SHIP);

		// Reset cycles plus every row plus margin
		timeout_limit = 2 + 50;
		foreach (entries[i])
			timeout_limit += entries[i].pulses * PULSE_CYCLES
				+ entries[i].frames * FRAME_CYCLES + PROBE_CYCLES;

		repeat (2) @(posedge clk);
		rst <= 1'b0;
		foreach (entries[i])
			apply_entry(entries[i]);

		if (checks_done == entries.size()) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			fail_run("not every table entry was checked");
		end
	end

endmodule
